//--- compile.f
+incdir+.
uart_frame_pkg.sv
uart_rx.sv
uart_tx.sv
frame_parser.sv
credit_fifo.sv
frame_sender.sv
uart_frame_top.sv
tb_uart_frame.sv

//--- run.sh
#!/bin/sh
# build and run the UART frame echo testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f compile.f --top-module tb_uart_frame -o sim_uart_frame
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_uart_frame > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
  echo "simulation FAILED"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
echo "simulation PASSED"
exit 0

//--- tb_uart_frame.sv
// assumes 8n1 at the rates of uart_frame_cfg.svh and frames that start aligned after reset
`timescale 1ns/10ps
`include "uart_frame_cfg.svh"

module tb_uart_frame;

  typedef uart_frame_pkg::byte_t byte_q_t [$];

  localparam int CPB   = `UF_CLKS_PER_BIT;
  localparam int DEPTH = `UF_FIFO_DEPTH;

  logic                 clk;
  logic                 rst;
  logic                 rx_uart;    // host to dut
  logic                 cts_n;
  logic                 tx_uart;    // echo back to host
  logic [`UF_CNT_W-1:0] frame_cnt;
  logic                 overrun;

  int      seed;
  int      n_total;    // bytes over all tests, sizes the watchdog
  int      n_checked;  // echoed bytes compared so far
  int      exp_frames; // frames expected since the last reset
  string   test_name;
  byte_q_t rx_q;       // bytes seen on tx_uart, not yet compared
  byte_q_t exp_q;      // bytes still owed by the dut
  byte_q_t stim2;
  byte_q_t stim_hdr;
  byte_q_t stim3;
  byte_q_t stim4;
  byte_q_t stim5;

  uart_frame_top u_dut (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_rx_uart   (rx_uart),
    .i_cts_n     (cts_n),
    .o_tx_uart   (tx_uart),
    .o_frame_cnt (frame_cnt),
    .o_overrun   (overrun)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
      $display("Checks failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // returns 1 ns after a rising edge, where inputs change
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic send_byte(input uart_frame_pkg::byte_t b);
    logic [9:0] bits;
    int         k;
    bits = {1'b1, b, 1'b0}; // start bit in bit 0
    for (k = 0; k < 10; k++) begin
      rx_uart = bits[k];
      wait_cycles(CPB);
    end
    wait_cycles(CPB); // one idle bit keeps the echo ahead of the input
  endtask

  task automatic send_stream(input byte_q_t q);
    foreach (q[k]) send_byte(q[k]);
  endtask

  // header of len, low byte first, then len-2 random payload bytes
  function automatic byte_q_t make_frame(input int len);
    byte_q_t                    q;
    uart_frame_pkg::frame_hdr_u hdr;
    int                         k;
    hdr.len = 16'(len);
    q.push_back(hdr.bytes[0]);
    q.push_back(hdr.bytes[1]);
    for (k = 2; k < len; k++) q.push_back(8'($random(seed)));
    return q;
  endfunction

  // expected echo of sent when only the first keep bytes get a credit; returns frames closed
  function automatic int expected_echo(input byte_q_t sent, input int keep,
                                       output byte_q_t exp);
    uart_frame_pkg::frame_hdr_u hdr;
    int                         pos;
    int                         frames;
    int                         k;
    logic                       last;
    pos    = 0;
    frames = 0;
    hdr    = '0;
    exp    = {};
    for (k = 0; k < sent.size(); k++) begin
      last = 1'b0;
      if (pos == 0) begin
        hdr.bytes[0] = sent[k];
      end else if (pos == 1) begin
        hdr.bytes[1] = sent[k];
        last = (hdr.len <= 16'd2); // header only frame
      end else begin
        last = (pos + 1 == int'(hdr.len)); // byte L closes it
      end
      pos = last ? 0 : pos + 1; // dropped bytes still move the position
      if (k < keep) begin
        exp.push_back(sent[k]);
        if (last) frames++;
      end
    end
    return frames;
  endfunction

  task automatic drain_wait();
    while (exp_q.size() > 0) wait_cycles(1); // watchdog bounds this
  endtask

  task automatic echo_test(input string name, input byte_q_t sent);
    byte_q_t exp;
    test_name  = name;
    exp_frames += expected_echo(sent, sent.size(), exp);
    exp_q      = exp;
    send_stream(sent);
    drain_wait();
    check_value({name, " frame count"}, exp_frames, 32'(frame_cnt));
  endtask

  // deserializer on tx_uart, samples at mid-bit on the falling edge
  initial begin : monitor
    uart_frame_pkg::byte_t b;
    int                    k;
    forever begin
      @(negedge clk);
      if (tx_uart === 1'b0) begin
        repeat (CPB / 2 - 1) @(negedge clk); // middle of start bit
        for (k = 0; k < 8; k++) begin
          repeat (CPB) @(negedge clk);
          b[k] = tx_uart; // lsb first
        end
        repeat (CPB) @(negedge clk);
        if (tx_uart !== 1'b1) begin
          $display("stop bit on the transmit line was not high during %s", test_name);
          $display("Checks failed");
          $fatal(1, "bad stop bit");
        end else begin
          rx_q.push_back(b);
        end
      end
    end
  end

  initial begin : compare
    uart_frame_pkg::byte_t got;
    uart_frame_pkg::byte_t want;
    forever begin
      @(posedge clk);
      while (rx_q.size() > 0) begin
        got = rx_q.pop_front();
        if (exp_q.size() == 0) begin
          $display("byte %0h was echoed but none was expected during %s", got, test_name);
          $display("Checks failed");
          $fatal(1, "unexpected echo");
        end else begin
          want = exp_q.pop_front();
          check_value($sformatf("%s byte %0d", test_name, n_checked), 32'(want), 32'(got));
          n_checked++;
        end
      end
    end
  end

  initial begin : watchdog
    while (n_total == 0) @(posedge clk);
    repeat (n_total * 12 * CPB + 2000) @(posedge clk);
    $display("timeout, the echo did not finish within %0d bytes of time", n_total);
    $display("Checks failed");
    $fatal(1, "watchdog expired");
  end

  initial begin : main
    byte_q_t exp;
    int      k;
    int      base;
    rst        = 1'b1;
    rx_uart    = 1'b1; // line idle
    cts_n      = 1'b0;
    seed       = 83651;
    n_checked  = 0;
    exp_frames = 0;
    test_name  = "reset";
    stim2    = make_frame(6);
    stim_hdr = {make_frame(0), make_frame(1), make_frame(2)};
    for (k = 0; k < 8; k++) stim3 = {stim3, make_frame(3 + int'($unsigned($random(seed)) % 18))};
    stim4   = make_frame(DEPTH + 1); // one byte more than the buffer holds
    stim5   = make_frame(6);
    n_total = stim2.size() + stim_hdr.size() + stim3.size() + stim4.size() + stim5.size();
    wait_cycles(8);
    rst = 1'b0;
    wait_cycles(2);
    check_value("reset tx line", 1, 32'(tx_uart));
    check_value("reset frame count", 0, 32'(frame_cnt));
    check_value("reset overrun", 0, 32'(overrun));
    echo_test("single frame", stim2);
    echo_test("header only frames", stim_hdr);
    echo_test("random frames", stim3);
    // echo paused, buffer fills, then one byte too many
    test_name  = "cts pause";
    cts_n      = 1'b1;
    base       = n_checked;
    exp_frames += expected_echo(stim4, DEPTH, exp);
    exp_q      = exp;
    for (k = 0; k < DEPTH; k++) send_byte(stim4[k]);
    check_value("cts pause overrun when full", 0, 32'(overrun));
    send_byte(stim4[DEPTH]);
    check_value("cts pause overrun after extra byte", 1, 32'(overrun));
    check_value("cts pause bytes echoed while paused", base, n_checked);
    cts_n = 1'b0;
    drain_wait();
    wait_cycles(12 * CPB); // room for a stray ninth byte to show up
    check_value("cts pause frame count", exp_frames, 32'(frame_cnt));
    rst = 1'b1;
    wait_cycles(8);
    rst        = 1'b0;
    exp_frames = 0;
    wait_cycles(2);
    check_value("second reset overrun", 0, 32'(overrun));
    check_value("second reset frame count", 0, 32'(frame_cnt));
    echo_test("frame after reset", stim5);
    $display("All checks passed");
    $finish;
  end

endmodule

//--- uart_frame_top.sv
// echo bridge for 8n1 links at UF_CLKS_PER_BIT clocks per bit; the sop tag is stored but unused
`timescale 1ns/10ps
`include "uart_frame_cfg.svh"

module uart_frame_top (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_rx_uart,
  input  logic                 i_cts_n,
  output logic                 o_tx_uart,
  output logic [`UF_CNT_W-1:0] o_frame_cnt,
  output logic                 o_overrun
);

  // rx to parser
  uart_frame_pkg::byte_t rx_byte;
  logic                  rx_valid;
  // parser to buffer, credit flow
  logic                  push;
  uart_frame_pkg::byte_t push_byte;
  logic                  push_sop;
  logic                  push_eop;
  logic                  credit;
  // buffer to sender
  logic                  head_valid;
  uart_frame_pkg::byte_t head_byte;
  logic                  head_eop;
  logic                  pop;
  // sender to tx
  logic                  tx_start;
  uart_frame_pkg::byte_t tx_byte;
  logic                  tx_busy;

  uart_rx u_rx (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rx       (i_rx_uart),
    .o_rx_byte  (rx_byte),
    .o_rx_valid (rx_valid)
  );

  frame_parser u_parser (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rx_valid (rx_valid),
    .i_rx_byte  (rx_byte),
    .i_credit   (credit),
    .o_push     (push),
    .o_byte     (push_byte),
    .o_sop      (push_sop),
    .o_eop      (push_eop),
    .o_overrun  (o_overrun)
  );

  credit_fifo u_fifo (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_push   (push),
    .i_byte   (push_byte),
    .i_sop    (push_sop),
    .i_eop    (push_eop),
    .i_pop    (pop),
    .o_valid  (head_valid),
    .o_byte   (head_byte),
    .o_sop    (),          // echo needs no start tag
    .o_eop    (head_eop),
    .o_credit (credit)
  );

  frame_sender u_sender (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_valid     (head_valid),
    .i_byte      (head_byte),
    .i_eop       (head_eop),
    .i_cts_n     (i_cts_n),
    .i_tx_busy   (tx_busy),
    .o_pop       (pop),
    .o_tx_start  (tx_start),
    .o_tx_byte   (tx_byte),
    .o_frame_cnt (o_frame_cnt)
  );

  uart_tx u_tx (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_tx_start (tx_start),
    .i_tx_byte  (tx_byte),
    .o_tx       (o_tx_uart),
    .o_tx_busy  (tx_busy)
  );

endmodule

//--- frame_sender.sv
// i_cts_n only holds back new bytes; a byte already handed to the transmitter always finishes
`timescale 1ns/10ps
`include "uart_frame_cfg.svh"

module frame_sender (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_valid,
  input  uart_frame_pkg::byte_t i_byte,
  input  logic                  i_eop,
  input  logic                  i_cts_n,
  input  logic                  i_tx_busy,
  output logic                  o_pop,
  output logic                  o_tx_start,
  output uart_frame_pkg::byte_t o_tx_byte,
  output logic [`UF_CNT_W-1:0]  o_frame_cnt
);

  logic fire;      // hand head byte to the transmitter
  logic pending_q; // start issued, busy not yet seen

  assign fire = i_valid && !i_cts_n && !i_tx_busy && !pending_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pending_q   <= 1'b0;
      o_frame_cnt <= '0;
    end else begin
      if (fire) begin
        pending_q <= 1'b1;
      end else if (i_tx_busy) begin
        pending_q <= 1'b0; // transmitter took it
      end
      if (fire && i_eop) o_frame_cnt <= o_frame_cnt + 1'b1; // last byte of a frame out
    end
  end

  // pop and start together, byte taken straight from the buffer head
  assign o_pop      = fire;
  assign o_tx_start = fire;
  assign o_tx_byte  = i_byte;

endmodule

//--- credit_fifo.sv
// push is not checked against full; the producer's credits keep it from overflowing
`timescale 1ns/10ps
`include "uart_frame_cfg.svh"

module credit_fifo (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_push,
  input  uart_frame_pkg::byte_t i_byte,
  input  logic                  i_sop,
  input  logic                  i_eop,
  input  logic                  i_pop,
  output logic                  o_valid,
  output uart_frame_pkg::byte_t o_byte,
  output logic                  o_sop,
  output logic                  o_eop,
  output logic                  o_credit
);

  localparam int DEPTH = `UF_FIFO_DEPTH;
  localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW    = $clog2(DEPTH + 1);
  localparam logic [AW-1:0] PTR_LAST = AW'(DEPTH - 1);

  logic [9:0]    mem [DEPTH]; // {sop, eop, byte}
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;       // occupancy
  logic          pop_ok;
  logic [9:0]    head;

  assign pop_ok = i_pop && (count != '0); // pop on empty is ignored

  always_ff @(posedge i_clk) begin
    if (i_push) mem[wr_ptr] <= {i_sop, i_eop, i_byte};
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1; // wrap, any depth
      if (pop_ok) rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      case ({i_push, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head entry shown while not empty
  assign head     = mem[rd_ptr];
  assign o_valid  = (count != '0);
  assign o_byte   = head[7:0];
  assign o_eop    = head[8];
  assign o_sop    = head[9];
  assign o_credit = pop_ok; // one credit back per pop, same cycle

endmodule

//--- frame_parser.sv
// no back-pressure on rx; with no credit left a byte is dropped and the overrun flag sticks
`timescale 1ns/10ps
`include "uart_frame_cfg.svh"

module frame_parser (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_rx_valid,
  input  uart_frame_pkg::byte_t i_rx_byte,
  input  logic                  i_credit,
  output logic                  o_push,
  output uart_frame_pkg::byte_t o_byte,
  output logic                  o_sop,
  output logic                  o_eop,
  output logic                  o_overrun
);

  localparam int CRD_W = $clog2(`UF_FIFO_DEPTH + 1);
  localparam logic [CRD_W-1:0] CRD_INIT = CRD_W'(`UF_FIFO_DEPTH);

  uart_frame_pkg::frame_hdr_u hdr_q;
  uart_frame_pkg::frame_hdr_u hdr_nxt;
  logic [15:0]      byte_cnt; // position within the frame
  logic [15:0]      cnt_nxt;
  logic             is_sop;
  logic             is_eop;
  logic [CRD_W-1:0] credit_q;
  logic             take;     // byte goes to the buffer

  // framing decision for the byte on i_rx_byte
  always_comb begin
    hdr_nxt = hdr_q;
    is_sop  = 1'b0;
    is_eop  = 1'b0;
    cnt_nxt = byte_cnt + 1'b1;
    if (byte_cnt == 16'd0) begin
      hdr_nxt.bytes[0] = i_rx_byte; // length low byte
      is_sop           = 1'b1;
    end else if (byte_cnt == 16'd1) begin
      hdr_nxt.bytes[1] = i_rx_byte; // length high byte
      if (hdr_nxt.len <= 16'd2) is_eop = 1'b1; // header only frame
    end else if ({1'b0, byte_cnt} + 17'd1 >= {1'b0, hdr_q.len}) begin
      is_eop = 1'b1; // byte L of the frame
    end
    if (is_eop) cnt_nxt = '0;
  end

  assign take = i_rx_valid && (credit_q != '0);

  // header capture, cleared implicitly by byte_cnt
  always_ff @(posedge i_clk) begin
    if (i_rx_valid) hdr_q <= hdr_nxt;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      byte_cnt  <= '0;
      credit_q  <= CRD_INIT;
      o_push    <= 1'b0;
      o_overrun <= 1'b0;
    end else begin
      o_push <= take;
      if (i_rx_valid) byte_cnt <= cnt_nxt;            // advances even on a drop
      if (i_rx_valid && !take) o_overrun <= 1'b1;     // sticky
      case ({take, i_credit})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q; // push and return cancel
      endcase
    end
  end

  // payload and tags, qualified by o_push
  always_ff @(posedge i_clk) begin
    if (take) begin
      o_byte <= i_rx_byte;
      o_sop  <= is_sop;
      o_eop  <= is_eop;
    end
  end

endmodule

//--- uart_tx.sv
// 8n1 only; i_tx_start is ignored while busy, so the caller must wait for o_tx_busy low
`timescale 1ns/10ps
`include "uart_frame_cfg.svh"

module uart_tx (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_tx_start,
  input  uart_frame_pkg::byte_t i_tx_byte,
  output logic                  o_tx,
  output logic                  o_tx_busy
);

  localparam int CNT_W = $clog2(`UF_CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`UF_CLKS_PER_BIT - 1);

  logic [9:0]       sh_q;    // stop, data, start with start in bit 0
  logic [CNT_W-1:0] clk_cnt;
  logic [3:0]       bit_cnt; // 0..9 over the 10 bit frame
  logic             busy_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      sh_q    <= '1; // line idles high
      clk_cnt <= '0;
      bit_cnt <= '0;
      busy_q  <= 1'b0;
    end else if (!busy_q) begin
      if (i_tx_start) begin
        sh_q    <= {1'b1, i_tx_byte, 1'b0};
        clk_cnt <= '0;
        bit_cnt <= '0;
        busy_q  <= 1'b1;
      end
    end else if (clk_cnt == BIT_LAST) begin
      clk_cnt <= '0;
      sh_q    <= {1'b1, sh_q[9:1]}; // refill with idle ones
      if (bit_cnt == 4'd9) begin
        busy_q <= 1'b0; // stop bit done
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // straight from a flop so the line never glitches
  assign o_tx      = sh_q[0];
  assign o_tx_busy = busy_q;

endmodule

//--- uart_rx.sv
// 8n1 only, no parity or baud detect; a low stop bit drops the byte with no error flag
`timescale 1ns/10ps
`include "uart_frame_cfg.svh"

module uart_rx (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_rx,
  output uart_frame_pkg::byte_t o_rx_byte,
  output logic                  o_rx_valid
);

  localparam int CNT_W = $clog2(`UF_CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`UF_CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`UF_CLKS_PER_BIT / 2 - 1);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_START = 2'd1;
  localparam logic [1:0] ST_DATA  = 2'd2;
  localparam logic [1:0] ST_STOP  = 2'd3;

  logic                  rx_meta;
  logic                  rx_sync;
  logic [1:0]            state;
  logic [CNT_W-1:0]      clk_cnt;
  logic [2:0]            bit_idx;
  uart_frame_pkg::byte_t shift_q;

  // two flop synchronizer, idles high like the line
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= i_rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state      <= ST_IDLE;
      clk_cnt    <= '0;
      bit_idx    <= '0;
      o_rx_valid <= 1'b0;
    end else begin
      o_rx_valid <= 1'b0; // single cycle pulse
      case (state)
        ST_IDLE: begin
          clk_cnt <= '0;
          if (!rx_sync) state <= ST_START; // falling edge seen
        end
        ST_START: begin
          if (clk_cnt == HALF_LAST) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? ST_IDLE : ST_DATA; // glitch goes back to idle
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        ST_DATA: begin
          if (clk_cnt == BIT_LAST) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= ST_STOP;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: begin // ST_STOP
          if (clk_cnt == BIT_LAST) begin
            o_rx_valid <= rx_sync; // framing error gives no pulse
            state      <= ST_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // data bits arrive lsb first, shift in from the top
  always_ff @(posedge i_clk) begin
    if (state == ST_DATA && clk_cnt == BIT_LAST) shift_q <= {rx_sync, shift_q[7:1]};
  end

  assign o_rx_byte = shift_q; // stable until the next byte starts shifting

endmodule

//--- uart_frame_pkg.sv
// types only; the length header arrives low byte first and counts its own two bytes
package uart_frame_pkg;

  // one data byte as carried on the serial link
  typedef logic [7:0] byte_t;

  // frame length header
  // filled byte by byte off the wire
  // then compared as a whole length
  typedef union packed {
    logic [15:0] len;   // whole length in bytes
    byte_t [1:0] bytes; // bytes[0] is the low byte and arrives first
  } frame_hdr_u;

endpackage

//--- uart_frame_cfg.svh
// single clock domain assumed; fifo depth also sets the starting credit count of the parser
`ifndef UART_FRAME_CFG_SVH
`define UART_FRAME_CFG_SVH

// serial bit period in i_clk cycles
// keep it even and >= 4 so the half-bit start check lands mid start bit
`define UF_CLKS_PER_BIT 16

// buffer entries, one tagged byte each
// also the number of credits the parser starts with
`define UF_FIFO_DEPTH 8

// width of the echoed frame counter, wraps silently
`define UF_CNT_W 16

`endif
